// ==== design/riscv_isa_pkg.sv ====
/*
 * RISC-V ISA definitions for the debug-entry monitor.
 * Machine word type, instruction word union and system encodings.
 */
`default_nettype none

package riscv_isa_pkg;

  typedef logic [31:0] xlen_t;

  // System instruction format (I-type with csr field)
  typedef struct packed {
    logic [11:0] csr;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } sys_fmt_t;

  // One retiring instruction word, seen raw or as system format
  typedef union packed {
    logic [31:0] raw;
    sys_fmt_t    sys;
  } insn_word_u;

  localparam xlen_t EBREAK_INSN  = 32'h0010_0073;
  localparam xlen_t CEBREAK_INSN = 32'h0000_9002;
  localparam xlen_t WFI_INSN     = 32'h1050_0073;
  localparam xlen_t DRET_INSN    = 32'h7B20_0073;
  localparam xlen_t ECALL_INSN   = 32'h0000_0073;

  // Word alignment
  localparam int unsigned WORD_ALIGN_BITS = 2;
  localparam xlen_t       WORD_ALIGN_MASK = ~xlen_t'((1 << WORD_ALIGN_BITS) - 1);

endpackage

`default_nettype wire

// ==== design/debug_pkg.sv ====
/*
 * Debug specification definitions.
 * Debug cause codes, controller states, dcsr and tdata1 bit positions.
 */
`default_nettype none

package debug_pkg;

  // Encoded as in dcsr.cause
  typedef enum logic [2:0] {
    NONE    = 3'd0,
    EBREAK  = 3'd1,
    TRIGGER = 3'd2,
    HALTREQ = 3'd3,
    STEP    = 3'd4
  } dbg_cause_e;

  typedef enum logic [2:0] {
    RESET       = 3'd0,
    BOOT_SET    = 3'd1,
    FUNCTIONAL  = 3'd2,
    DEBUG_TAKEN = 3'd3,
    SLEEP       = 3'd4
  } ctrl_state_e;

  localparam int unsigned DCSR_STEP_BIT    = 2;
  localparam int unsigned DCSR_EBREAKM_BIT = 15;
  localparam int unsigned TDATA1_EXEC_BIT  = 2;

endpackage

`default_nettype wire

// ==== design/retire_event_if.sv ====
/*
 * Classified writeback retirement events.
 */
`timescale 1ns/1ps
`default_nettype none

interface retire_event_if;
  import riscv_isa_pkg::*;

  logic  retire;
  logic  ebreak;
  logic  wfi;
  logic  dret;
  logic  ecall;
  logic  trigger_hit;
  xlen_t pc;

  modport classifier (output retire, ebreak, wfi, dret, ecall, trigger_hit, pc);
  modport tracker    (input  retire, ebreak, wfi, dret, ecall, trigger_hit, pc);

endinterface

`default_nettype wire

// ==== design/wb_retire_classifier.sv ====
/*
 * Writeback retirement classifier.
 * Recognizes ebreak, c.ebreak, wfi, dret, ecall and trigger address hits.
 */
`timescale 1ns/1ps
`default_nettype none

module wb_retire_classifier (
  input  wire logic                     wb_valid_i,
  input  wire logic                     wb_err_i,
  input  wire riscv_isa_pkg::insn_word_u wb_instr_i,
  input  wire riscv_isa_pkg::xlen_t     wb_pc_i,
  input  wire riscv_isa_pkg::xlen_t     tdata1_i,
  input  wire riscv_isa_pkg::xlen_t     tdata2_i,
  retire_event_if.classifier            evt
);
  import riscv_isa_pkg::*;
  import debug_pkg::*;

  localparam logic [6:0] OPC_SYSTEM = 7'h73;

  logic retire;
  logic sys_plain;
  logic cebreak_hit;

  assign retire = wb_valid_i && !wb_err_i;

  // System opcode with funct3, rd and rs1 all zero
  assign sys_plain = (wb_instr_i.sys.opcode == OPC_SYSTEM)
                  && (wb_instr_i.sys.funct3 == 3'b000)
                  && (wb_instr_i.sys.rd == 5'd0)
                  && (wb_instr_i.sys.rs1 == 5'd0);

  // Low half only; a 32-bit encoding never ends in 2'b10
  assign cebreak_hit = {wb_instr_i.sys.rs1[0], wb_instr_i.sys.funct3,
                        wb_instr_i.sys.rd, wb_instr_i.sys.opcode} == CEBREAK_INSN[15:0];

  assign evt.retire = retire;
  assign evt.ebreak = retire && ((sys_plain && (wb_instr_i.raw == EBREAK_INSN)) || cebreak_hit);
  assign evt.wfi    = retire && sys_plain && (wb_instr_i.raw == WFI_INSN);
  assign evt.dret   = retire && sys_plain && (wb_instr_i.raw == DRET_INSN);
  assign evt.ecall  = retire && sys_plain && (wb_instr_i.raw == ECALL_INSN);
  assign evt.pc     = wb_pc_i;

  // Execute address trigger
  assign evt.trigger_hit = retire && (wb_pc_i == tdata2_i) && tdata1_i[TDATA1_EXEC_BIT];

endmodule

`default_nettype wire

// ==== design/debug_cause_tracker.sv ====
/*
 * Expected debug cause with fixed priority, wfi sleep state and
 * detection of the first instruction retired in debug mode.
 */
`timescale 1ns/1ps
`default_nettype none

module debug_cause_tracker #(
  parameter int unsigned NUM_IRQ = 32
) (
  input  wire logic                    cov_assert_if,
  input  wire logic                    arst_n_i,
  retire_event_if.tracker              evt,
  input  wire logic                    debug_mode_i,
  input  wire logic                    debug_req_i,
  input  wire debug_pkg::ctrl_state_e  ctrl_state_i,
  input  wire riscv_isa_pkg::xlen_t    dcsr_i,
  input  wire logic                    id_valid_i,
  input  wire logic [NUM_IRQ-1:0]      irq_i,
  input  wire logic [NUM_IRQ-1:0]      mie_i,
  output debug_pkg::dbg_cause_e        expected_cause_o,
  output logic                         started_decoding_o,
  output logic                         in_wfi_o,
  output logic                         first_debug_ins_o
);
  import debug_pkg::*;

  logic step_en;
  logic ebreakm_en;
  logic irq_pending;
  logic retired_in_debug_q;

  assign step_en     = dcsr_i[DCSR_STEP_BIT];
  assign ebreakm_en  = dcsr_i[DCSR_EBREAKM_BIT];
  assign irq_pending = |(irq_i & mie_i);

  // --------------------
  // Expected cause, frozen inside debug mode
  always_ff @(posedge cov_assert_if or negedge arst_n_i) begin
    if (!arst_n_i) begin
      expected_cause_o <= NONE;
    end else if (!debug_mode_i) begin
      if (evt.trigger_hit) begin
        expected_cause_o <= TRIGGER;
      end else if (evt.ebreak && ebreakm_en) begin
        expected_cause_o <= EBREAK;
      end else if (debug_req_i && (ctrl_state_i == FUNCTIONAL)) begin
        expected_cause_o <= HALTREQ;
      end else if (step_en && (expected_cause_o inside {NONE, STEP})) begin
        expected_cause_o <= STEP;
      end else if (ctrl_state_i == FUNCTIONAL) begin
        expected_cause_o <= NONE;
      end
    end
  end

  // --------------------
  // Sleep state, wake-up wins over entry
  always_ff @(posedge cov_assert_if or negedge arst_n_i) begin
    if (!arst_n_i) begin
      in_wfi_o <= 1'b0;
    end else begin
      if (evt.wfi && !debug_mode_i && !step_en && !debug_req_i) begin
        in_wfi_o <= 1'b1;
      end
      if (irq_pending || debug_req_i) begin
        in_wfi_o <= 1'b0;
      end
    end
  end

  // --------------------
  // Debug session progress
  always_ff @(posedge cov_assert_if or negedge arst_n_i) begin
    if (!arst_n_i) begin
      started_decoding_o <= 1'b0;
      retired_in_debug_q <= 1'b0;
    end else if (debug_mode_i) begin
      if (id_valid_i) begin
        started_decoding_o <= 1'b1;
      end
      if (evt.retire) begin
        retired_in_debug_q <= 1'b1;
      end
    end else begin
      started_decoding_o <= 1'b0;
      retired_in_debug_q <= 1'b0;
    end
  end

  assign first_debug_ins_o = debug_mode_i && evt.retire && !retired_in_debug_q
                          && started_decoding_o;

endmodule

`default_nettype wire

// ==== design/dpc_predictor.sv ====
/*
 * Predicts the value dpc takes at debug entry and keeps the pc of
 * the most recent ebreak.
 */
`timescale 1ns/1ps
`default_nettype none

module dpc_predictor #(
  parameter int unsigned NUM_IRQ = 32
) (
  input  wire logic                        cov_assert_if,
  input  wire logic                        arst_n_i,
  retire_event_if.tracker                  evt,
  input  wire riscv_isa_pkg::xlen_t        wb_next_pc_i,
  input  wire debug_pkg::ctrl_state_e      ctrl_state_i,
  input  wire riscv_isa_pkg::xlen_t        boot_addr_i,
  input  wire riscv_isa_pkg::xlen_t        mtvec_i,
  input  wire logic                        irq_ack_i,
  input  wire logic [$clog2(NUM_IRQ)-1:0]  irq_id_i,
  input  wire logic                        debug_mode_i,
  input  wire debug_pkg::dbg_cause_e       expected_cause_i,
  input  wire logic                        started_decoding_i,
  output riscv_isa_pkg::xlen_t             expected_dpc_o,
  output riscv_isa_pkg::xlen_t             ebreak_pc_o
);
  import riscv_isa_pkg::*;
  import debug_pkg::*;

  localparam logic [1:0] MTVEC_DIRECT   = 2'b00;
  localparam logic [1:0] MTVEC_VECTORED = 2'b01;

  xlen_t mtvec_base;
  xlen_t dpc_d;

  assign mtvec_base = mtvec_i & WORD_ALIGN_MASK;

  // Later sources override earlier ones
  always_comb begin
    dpc_d = expected_dpc_o;
    if (ctrl_state_i == BOOT_SET) begin
      dpc_d = boot_addr_i & WORD_ALIGN_MASK;
    end
    if (evt.retire) begin
      if ((expected_cause_i inside {EBREAK, TRIGGER}) && !started_decoding_i) begin
        dpc_d = evt.pc;
      end else begin
        dpc_d = wb_next_pc_i;
      end
    end
    if (evt.trigger_hit) begin
      dpc_d = evt.pc;
    end
    if (irq_ack_i) begin
      if (mtvec_i[1:0] == MTVEC_DIRECT) begin
        dpc_d = mtvec_base;
      end else if (mtvec_i[1:0] == MTVEC_VECTORED) begin
        dpc_d = mtvec_base + (xlen_t'(irq_id_i) << WORD_ALIGN_BITS);
      end
    end
    // Debug code is running, dpc is settled
    if (debug_mode_i && started_decoding_i) begin
      dpc_d = expected_dpc_o;
    end
  end

  always_ff @(posedge cov_assert_if or negedge arst_n_i) begin
    if (!arst_n_i) begin
      expected_dpc_o <= '0;
      ebreak_pc_o    <= '0;
    end else begin
      expected_dpc_o <= dpc_d;
      if (evt.ebreak) begin
        ebreak_pc_o <= evt.pc;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/debug_entry_capture.sv ====
/*
 * Captures the halt address and tdata2 at debug entry and the
 * exception address taken inside debug mode.
 */
`timescale 1ns/1ps
`default_nettype none

module debug_entry_capture (
  input  wire logic                    cov_assert_if,
  input  wire logic                    arst_n_i,
  retire_event_if.tracker              evt,
  input  wire debug_pkg::ctrl_state_e  ctrl_state_i,
  input  wire logic                    debug_mode_i,
  input  wire riscv_isa_pkg::xlen_t    dm_halt_addr_i,
  input  wire riscv_isa_pkg::xlen_t    dm_exception_addr_i,
  input  wire riscv_isa_pkg::xlen_t    tdata2_i,
  input  wire logic                    illegal_insn_i,
  input  wire logic                    pc_set_i,
  output riscv_isa_pkg::xlen_t         halt_addr_o,
  output riscv_isa_pkg::xlen_t         exception_addr_o
);
  import riscv_isa_pkg::*;
  import debug_pkg::*;

  logic  entry_captured_q;
  logic  capture_en;
  xlen_t tdata2_at_entry;

  assign capture_en = (ctrl_state_i == DEBUG_TAKEN) && !entry_captured_q;

  // Re-arm on leaving debug mode, on ebreak re-entry, or on dret
  always_ff @(posedge cov_assert_if or negedge arst_n_i) begin
    if (!arst_n_i) begin
      entry_captured_q <= 1'b0;
    end else begin
      if (capture_en) begin
        entry_captured_q <= 1'b1;
      end
      if (!debug_mode_i || evt.ebreak || evt.dret) begin
        entry_captured_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge cov_assert_if) begin
    if (capture_en) begin
      halt_addr_o     <= dm_halt_addr_i & WORD_ALIGN_MASK;
      tdata2_at_entry <= tdata2_i;
    end
    if ((illegal_insn_i || evt.ecall) && pc_set_i && debug_mode_i && evt.retire) begin
      exception_addr_o <= dm_exception_addr_i & WORD_ALIGN_MASK;
    end
  end

endmodule

`default_nettype wire

// ==== design/debug_monitor.sv ====
/*
 * Debug-entry monitor top level.
 * Classifier feeding the cause tracker, dpc predictor and entry capture.
 */
`timescale 1ns/1ps
`default_nettype none

module debug_monitor #(
  parameter int unsigned NUM_IRQ = 32
) (
  input  wire logic                        cov_assert_if,
  input  wire logic                        arst_n_i,
  // Writeback stage
  input  wire logic                        wb_valid_i,
  input  wire logic                        wb_err_i,
  input  wire riscv_isa_pkg::insn_word_u   wb_instr_i,
  input  wire riscv_isa_pkg::xlen_t        wb_pc_i,
  input  wire riscv_isa_pkg::xlen_t        wb_next_pc_i,
  input  wire logic                        id_valid_i,
  // Core state
  input  wire logic                        debug_mode_i,
  input  wire logic                        debug_req_i,
  input  wire debug_pkg::ctrl_state_e      ctrl_state_i,
  // CSRs
  input  wire riscv_isa_pkg::xlen_t        dcsr_i,
  input  wire riscv_isa_pkg::xlen_t        tdata1_i,
  input  wire riscv_isa_pkg::xlen_t        tdata2_i,
  input  wire riscv_isa_pkg::xlen_t        mtvec_i,
  // Interrupts
  input  wire logic [NUM_IRQ-1:0]          irq_i,
  input  wire logic [NUM_IRQ-1:0]          mie_i,
  input  wire logic                        irq_ack_i,
  input  wire logic [$clog2(NUM_IRQ)-1:0]  irq_id_i,
  // Fixed addresses and exceptions
  input  wire riscv_isa_pkg::xlen_t        boot_addr_i,
  input  wire riscv_isa_pkg::xlen_t        dm_halt_addr_i,
  input  wire riscv_isa_pkg::xlen_t        dm_exception_addr_i,
  input  wire logic                        illegal_insn_i,
  input  wire logic                        pc_set_i,
  // Predictions
  output debug_pkg::dbg_cause_e            expected_cause_o,
  output riscv_isa_pkg::xlen_t             expected_dpc_o,
  output riscv_isa_pkg::xlen_t             ebreak_pc_o,
  output riscv_isa_pkg::xlen_t             halt_addr_o,
  output riscv_isa_pkg::xlen_t             exception_addr_o,
  output logic                             in_wfi_o,
  output logic                             first_debug_ins_o,
  output logic                             trigger_hit_o
);
  import debug_pkg::*;

  dbg_cause_e expected_cause;
  logic       started_decoding;

  retire_event_if evt_if ();

  wb_retire_classifier classifier_inst (
    .wb_valid_i (wb_valid_i),
    .wb_err_i   (wb_err_i),
    .wb_instr_i (wb_instr_i),
    .wb_pc_i    (wb_pc_i),
    .tdata1_i   (tdata1_i),
    .tdata2_i   (tdata2_i),
    .evt        (evt_if.classifier)
  );

  debug_cause_tracker #(.NUM_IRQ(NUM_IRQ)) cause_tracker_inst (
    .cov_assert_if (cov_assert_if), .arst_n_i (arst_n_i), .evt (evt_if.tracker),
    .debug_mode_i (debug_mode_i), .debug_req_i (debug_req_i),
    .ctrl_state_i (ctrl_state_i), .dcsr_i (dcsr_i), .id_valid_i (id_valid_i),
    .irq_i (irq_i), .mie_i (mie_i),
    .expected_cause_o (expected_cause), .started_decoding_o (started_decoding),
    .in_wfi_o (in_wfi_o), .first_debug_ins_o (first_debug_ins_o)
  );

  dpc_predictor #(.NUM_IRQ(NUM_IRQ)) dpc_predictor_inst (
    .cov_assert_if (cov_assert_if), .arst_n_i (arst_n_i), .evt (evt_if.tracker),
    .wb_next_pc_i (wb_next_pc_i), .ctrl_state_i (ctrl_state_i),
    .boot_addr_i (boot_addr_i), .mtvec_i (mtvec_i),
    .irq_ack_i (irq_ack_i), .irq_id_i (irq_id_i), .debug_mode_i (debug_mode_i),
    .expected_cause_i (expected_cause), .started_decoding_i (started_decoding),
    .expected_dpc_o (expected_dpc_o), .ebreak_pc_o (ebreak_pc_o)
  );

  debug_entry_capture entry_capture_inst (
    .cov_assert_if (cov_assert_if), .arst_n_i (arst_n_i), .evt (evt_if.tracker),
    .ctrl_state_i (ctrl_state_i), .debug_mode_i (debug_mode_i),
    .dm_halt_addr_i (dm_halt_addr_i), .dm_exception_addr_i (dm_exception_addr_i),
    .tdata2_i (tdata2_i), .illegal_insn_i (illegal_insn_i), .pc_set_i (pc_set_i),
    .halt_addr_o (halt_addr_o), .exception_addr_o (exception_addr_o)
  );

  assign expected_cause_o = expected_cause;
  assign trigger_hit_o    = evt_if.trigger_hit;

endmodule

`default_nettype wire

// ==== verif/debug_monitor_sva.sv ====
/*
 * Concurrent assertions for the debug-entry monitor.
 * Bound to the top level: frozen cause, wfi wake-up, address alignment.
 */
`timescale 1ns/1ps
`default_nettype none

module debug_monitor_sva #(
  parameter int unsigned NUM_IRQ = 32
) (
  input wire logic                  cov_assert_if,
  input wire logic                  arst_n_i,
  input wire logic                  debug_mode_i,
  input wire logic [NUM_IRQ-1:0]    irq_i,
  input wire logic [NUM_IRQ-1:0]    mie_i,
  input wire debug_pkg::dbg_cause_e expected_cause_i,
  input wire logic                  in_wfi_i,
  input wire riscv_isa_pkg::xlen_t  halt_addr_i,
  input wire riscv_isa_pkg::xlen_t  exception_addr_i
);
  import riscv_isa_pkg::*;

  // Cause stays put for the whole debug session
  cause_frozen_in_debug: assert property (
    @(posedge cov_assert_if) disable iff (!arst_n_i)
    debug_mode_i |=> $stable(expected_cause_i)
  ) else $error("Expected debug cause changed inside debug mode");

  // Pending enabled interrupt wakes the core
  wfi_wakes_on_irq: assert property (
    @(posedge cov_assert_if) disable iff (!arst_n_i)
    (|(irq_i & mie_i)) |=> !in_wfi_i
  ) else $error("Sleep state still set after a pending enabled interrupt");

  // --------------------
  // Captured addresses are word aligned
  halt_addr_aligned: assert property (
    @(posedge cov_assert_if) disable iff (!arst_n_i)
    !$isunknown(halt_addr_i) |-> (halt_addr_i[WORD_ALIGN_BITS-1:0] == '0)
  ) else $error("Captured halt address is not word aligned");

  exception_addr_aligned: assert property (
    @(posedge cov_assert_if) disable iff (!arst_n_i)
    !$isunknown(exception_addr_i) |-> (exception_addr_i[WORD_ALIGN_BITS-1:0] == '0)
  ) else $error("Captured exception address is not word aligned");

endmodule

bind debug_monitor debug_monitor_sva #(.NUM_IRQ(NUM_IRQ)) sva_inst (
  .cov_assert_if    (cov_assert_if),
  .arst_n_i         (arst_n_i),
  .debug_mode_i     (debug_mode_i),
  .irq_i            (irq_i),
  .mie_i            (mie_i),
  .expected_cause_i (expected_cause_o),
  .in_wfi_i         (in_wfi_o),
  .halt_addr_i      (halt_addr_o),
  .exception_addr_i (exception_addr_o)
);

`default_nettype wire

// ==== verif/debug_monitor_tb.sv ====
/*
 * Testbench for the debug-entry monitor.
 * Clock, reset, stimulus table with expected outputs, checks per row.
 */
`timescale 1ns/1ps
`default_nettype none

module debug_monitor_tb;
  import riscv_isa_pkg::*;
  import debug_pkg::*;

  localparam int unsigned NUM_IRQ    = 32;
  localparam int unsigned WAIT_LIMIT = 20;
  localparam logic [$clog2(NUM_IRQ)-1:0] IRQ_ID = 5;

  localparam xlen_t NOP_INSN  = 32'h0000_0013;
  localparam xlen_t TRIG_ADDR = 32'h0000_0200;
  localparam xlen_t MTVEC_VEC = 32'h0000_1001;
  localparam xlen_t BOOT_ADDR = 32'h0000_8003;
  localparam xlen_t DM_A      = 32'h1A11_0802;
  localparam xlen_t DM_B      = 32'h1A11_0F00;
  localparam xlen_t DM_C      = 32'h1A11_0813;
  localparam xlen_t HALT_A    = 32'h1A11_0800;
  localparam xlen_t EXC_A     = 32'h1A11_0810;
  localparam xlen_t NO_CHK    = 32'h0;

  // One stimulus flag per control input
  localparam logic [11:0] F_NONE = 12'h000;
  localparam logic [11:0] F_VAL  = 12'h001;
  localparam logic [11:0] F_ERR  = 12'h002;
  localparam logic [11:0] F_IDV  = 12'h004;
  localparam logic [11:0] F_DBG  = 12'h008;
  localparam logic [11:0] F_REQ  = 12'h010;
  localparam logic [11:0] F_IRQ  = 12'h020;
  localparam logic [11:0] F_ACK  = 12'h040;
  localparam logic [11:0] F_PCS  = 12'h080;
  localparam logic [11:0] F_STP  = 12'h100;
  localparam logic [11:0] F_EBM  = 12'h200;
  localparam logic [11:0] F_TEN  = 12'h400;

  // Expected bits from msb are exception check, halt check, in_wfi, first_debug_ins, trigger_hit
  typedef struct packed {
    ctrl_state_e state;
    logic [11:0] flags;
    xlen_t       instr;
    xlen_t       pc;
    xlen_t       next_pc;
    xlen_t       dm_addr;
    dbg_cause_e  exp_cause;
    xlen_t       exp_dpc;
    xlen_t       exp_ebreak_pc;
    xlen_t       exp_halt;
    xlen_t       exp_exc;
    logic [4:0]  exp_bits;
  } row_t;

  logic                       cov_assert_if;
  logic                       arst_n_i;
  logic                       wb_valid_i, wb_err_i, id_valid_i;
  insn_word_u                 wb_instr_i;
  xlen_t                      wb_pc_i, wb_next_pc_i;
  logic                       debug_mode_i, debug_req_i;
  ctrl_state_e                ctrl_state_i;
  xlen_t                      dcsr_i, tdata1_i, tdata2_i, mtvec_i;
  logic [NUM_IRQ-1:0]         irq_i, mie_i;
  logic                       irq_ack_i;
  logic [$clog2(NUM_IRQ)-1:0] irq_id_i;
  xlen_t                      boot_addr_i, dm_halt_addr_i, dm_exception_addr_i;
  logic                       illegal_insn_i, pc_set_i;
  dbg_cause_e                 expected_cause_o;
  xlen_t                      expected_dpc_o, ebreak_pc_o, halt_addr_o, exception_addr_o;
  logic                       in_wfi_o, first_debug_ins_o, trigger_hit_o;

  row_t        rows[$];
  string       row_names[$];
  int unsigned edge_cnt = 0;

  debug_monitor #(.NUM_IRQ(NUM_IRQ)) debug_monitor_inst (.*);

  initial begin
    cov_assert_if = 1'b0;
    forever #5 cov_assert_if = ~cov_assert_if;
  end

  always @(posedge cov_assert_if) begin
    edge_cnt <= edge_cnt + 1;
  end

  // --------------------
  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1, "Run aborted");
  endtask

  // Polls on even times and edges fall on odd ones, so it returns 1 ns after the edge
  task automatic wait_edge();
    int unsigned start_cnt;
    int unsigned polls;
    start_cnt = edge_cnt;
    polls     = 0;
    while ((edge_cnt == start_cnt) && (polls < WAIT_LIMIT)) begin
      #2;
      polls++;
    end
    if (edge_cnt == start_cnt) begin
      stop_run("Timeout: no rising clock edge within the wait limit");
    end
  endtask

  task automatic check_word(input string test, input string what,
                            input xlen_t exp, input xlen_t act);
    assert (act === exp) else begin
      stop_run($sformatf("MISMATCH %s %s: expected %h actual %h", test, what, exp, act));
    end
  endtask

  task automatic add_row(input string name, input ctrl_state_e state,
                         input logic [11:0] flags, input xlen_t instr, input xlen_t pc,
                         input xlen_t next_pc, input xlen_t dm_addr,
                         input dbg_cause_e exp_cause, input xlen_t exp_dpc,
                         input xlen_t exp_ebreak_pc, input xlen_t exp_halt,
                         input xlen_t exp_exc, input logic [4:0] exp_bits);
    rows.push_back('{state, flags, instr, pc, next_pc, dm_addr, exp_cause, exp_dpc,
                     exp_ebreak_pc, exp_halt, exp_exc, exp_bits});
    row_names.push_back(name);
  endtask

  task automatic drive_row(input row_t r);
    ctrl_state_i        = r.state;
    wb_valid_i          = |(r.flags & F_VAL);
    wb_err_i            = |(r.flags & F_ERR);
    id_valid_i          = |(r.flags & F_IDV);
    debug_mode_i        = |(r.flags & F_DBG);
    debug_req_i         = |(r.flags & F_REQ);
    irq_ack_i           = |(r.flags & F_ACK);
    pc_set_i            = |(r.flags & F_PCS);
    irq_i               = '0;
    irq_i[IRQ_ID]       = |(r.flags & F_IRQ);
    dcsr_i              = '0;
    dcsr_i[DCSR_STEP_BIT]    = |(r.flags & F_STP);
    dcsr_i[DCSR_EBREAKM_BIT] = |(r.flags & F_EBM);
    tdata1_i            = '0;
    tdata1_i[TDATA1_EXEC_BIT] = |(r.flags & F_TEN);
    wb_instr_i.raw      = r.instr;
    wb_pc_i             = r.pc;
    wb_next_pc_i        = r.next_pc;
    dm_halt_addr_i      = r.dm_addr;
    dm_exception_addr_i = r.dm_addr;
  endtask

  task automatic init_inputs();
    row_t idle;
    idle       = '0;
    idle.state = RESET;
    idle.instr = NOP_INSN;
    drive_row(idle);
    tdata2_i       = TRIG_ADDR;
    mtvec_i        = MTVEC_VEC;
    boot_addr_i    = BOOT_ADDR;
    irq_id_i       = IRQ_ID;
    mie_i          = '0;
    mie_i[IRQ_ID]  = 1'b1;
    illegal_insn_i = 1'b0;
  endtask

  // --------------------
  // Expected values follow the priority and update rules of the monitor
  task automatic build_table();
    add_row("reset_vals", RESET, F_NONE, NOP_INSN, 32'h0, 32'h0, DM_A,
            NONE, 32'h0, 32'h0, NO_CHK, NO_CHK, 5'b00_000);
    add_row("boot_set", BOOT_SET, F_NONE, NOP_INSN, 32'h0, 32'h0, DM_A,
            NONE, 32'h8000, 32'h0, NO_CHK, NO_CHK, 5'b00_000);
    add_row("plain_retire", FUNCTIONAL, F_VAL, NOP_INSN, 32'h8000, 32'h8004, DM_A,
            NONE, 32'h8004, 32'h0, NO_CHK, NO_CHK, 5'b00_000);
    add_row("prio_trig", FUNCTIONAL, F_VAL|F_EBM|F_TEN, EBREAK_INSN, 32'h200, 32'h204, DM_A,
            TRIGGER, 32'h200, 32'h200, NO_CHK, NO_CHK, 5'b00_001);
    add_row("prio_ebreak", FUNCTIONAL, F_VAL|F_EBM, EBREAK_INSN, 32'h300, 32'h304, DM_A,
            EBREAK, 32'h300, 32'h300, NO_CHK, NO_CHK, 5'b00_000);
    add_row("prio_haltreq", FUNCTIONAL, F_REQ, NOP_INSN, 32'h0, 32'h0, DM_A,
            HALTREQ, 32'h300, 32'h300, NO_CHK, NO_CHK, 5'b00_000);
    add_row("step_blocked", FUNCTIONAL, F_STP, NOP_INSN, 32'h0, 32'h0, DM_A,
            NONE, 32'h300, 32'h300, NO_CHK, NO_CHK, 5'b00_000);
    add_row("prio_step", FUNCTIONAL, F_STP, NOP_INSN, 32'h0, 32'h0, DM_A,
            STEP, 32'h300, 32'h300, NO_CHK, NO_CHK, 5'b00_000);
    add_row("dbg_trig", FUNCTIONAL, F_DBG|F_VAL|F_EBM|F_TEN, EBREAK_INSN, 32'h200, 32'h204, DM_A,
            STEP, 32'h200, 32'h200, NO_CHK, NO_CHK, 5'b00_001);
    add_row("dbg_req_step", FUNCTIONAL, F_DBG|F_REQ|F_STP, NOP_INSN, 32'h0, 32'h0, DM_A,
            STEP, 32'h200, 32'h200, NO_CHK, NO_CHK, 5'b00_000);
    add_row("wfi_enter", FUNCTIONAL, F_VAL, WFI_INSN, 32'h400, 32'h404, DM_A,
            NONE, 32'h404, 32'h200, NO_CHK, NO_CHK, 5'b00_100);
    add_row("wfi_hold", FUNCTIONAL, F_NONE, NOP_INSN, 32'h0, 32'h0, DM_A,
            NONE, 32'h404, 32'h200, NO_CHK, NO_CHK, 5'b00_100);
    add_row("wfi_wake_irq", FUNCTIONAL, F_IRQ, NOP_INSN, 32'h0, 32'h0, DM_A,
            NONE, 32'h404, 32'h200, NO_CHK, NO_CHK, 5'b00_000);
    add_row("wfi_reenter", FUNCTIONAL, F_VAL, WFI_INSN, 32'h408, 32'h40C, DM_A,
            NONE, 32'h40C, 32'h200, NO_CHK, NO_CHK, 5'b00_100);
    add_row("wfi_wake_req", FUNCTIONAL, F_REQ, NOP_INSN, 32'h0, 32'h0, DM_A,
            HALTREQ, 32'h40C, 32'h200, NO_CHK, NO_CHK, 5'b00_000);
    add_row("wfi_step", FUNCTIONAL, F_VAL|F_STP, WFI_INSN, 32'h410, 32'h414, DM_A,
            NONE, 32'h414, 32'h200, NO_CHK, NO_CHK, 5'b00_000);
    add_row("irq_ack_vec", FUNCTIONAL, F_ACK, NOP_INSN, 32'h0, 32'h0, DM_A,
            NONE, 32'h1014, 32'h200, NO_CHK, NO_CHK, 5'b00_000);
    add_row("cebreak_pc", FUNCTIONAL, F_VAL|F_EBM, CEBREAK_INSN, 32'h500, 32'h502, DM_A,
            EBREAK, 32'h502, 32'h500, NO_CHK, NO_CHK, 5'b00_000);
    add_row("dbg_taken", DEBUG_TAKEN, F_DBG, NOP_INSN, 32'h0, 32'h0, DM_A,
            EBREAK, 32'h502, 32'h500, HALT_A, NO_CHK, 5'b01_000);
    add_row("dbg_taken_again", DEBUG_TAKEN, F_DBG|F_IDV, NOP_INSN, 32'h0, 32'h0, DM_B,
            EBREAK, 32'h502, 32'h500, HALT_A, NO_CHK, 5'b01_000);
    add_row("first_dbg_ins", FUNCTIONAL, F_DBG|F_VAL, NOP_INSN, 32'h800, 32'h804, DM_A,
            EBREAK, 32'h502, 32'h500, HALT_A, NO_CHK, 5'b01_010);
    add_row("second_dbg_ins", FUNCTIONAL, F_DBG|F_VAL, NOP_INSN, 32'h804, 32'h808, DM_A,
            EBREAK, 32'h502, 32'h500, HALT_A, NO_CHK, 5'b01_000);
    add_row("ecall_dbg", FUNCTIONAL, F_DBG|F_VAL|F_PCS, ECALL_INSN, 32'h808, 32'h80C, DM_C,
            EBREAK, 32'h502, 32'h500, HALT_A, EXC_A, 5'b11_000);
    add_row("leave_dbg", FUNCTIONAL, F_NONE, NOP_INSN, 32'h0, 32'h0, DM_A,
            NONE, 32'h502, 32'h500, HALT_A, EXC_A, 5'b11_000);
    add_row("err_no_retire", FUNCTIONAL, F_VAL|F_ERR|F_EBM, EBREAK_INSN, 32'h600, 32'h604, DM_A,
            NONE, 32'h502, 32'h500, HALT_A, EXC_A, 5'b11_000);
    add_row("ebreak_cause", FUNCTIONAL, F_VAL|F_EBM, EBREAK_INSN, 32'h700, 32'h704, DM_A,
            EBREAK, 32'h704, 32'h700, HALT_A, EXC_A, 5'b11_000);
    add_row("ebreak_dpc", FUNCTIONAL, F_VAL|F_EBM, EBREAK_INSN, 32'h710, 32'h714, DM_A,
            EBREAK, 32'h710, 32'h710, HALT_A, EXC_A, 5'b11_000);
  endtask

  task automatic check_registered(input string name, input row_t r);
    check_word(name, "expected_cause_o", xlen_t'(r.exp_cause), xlen_t'(expected_cause_o));
    check_word(name, "expected_dpc_o", r.exp_dpc, expected_dpc_o);
    check_word(name, "ebreak_pc_o", r.exp_ebreak_pc, ebreak_pc_o);
    check_word(name, "in_wfi_o", xlen_t'(r.exp_bits[2]), xlen_t'(in_wfi_o));
    if (r.exp_bits[3]) begin
      check_word(name, "halt_addr_o", r.exp_halt, halt_addr_o);
    end
    if (r.exp_bits[4]) begin
      check_word(name, "exception_addr_o", r.exp_exc, exception_addr_o);
    end
  endtask

  // --------------------
  initial begin
    arst_n_i = 1'b0;
    init_inputs();
    build_table();
    repeat (3) wait_edge();
    arst_n_i = 1'b1;

    for (int i = 0; i < rows.size(); i++) begin
      drive_row(rows[i]);
      // Combinational outputs mid-cycle
      #2;
      check_word(row_names[i], "trigger_hit_o", xlen_t'(rows[i].exp_bits[0]),
                 xlen_t'(trigger_hit_o));
      check_word(row_names[i], "first_debug_ins_o", xlen_t'(rows[i].exp_bits[1]),
                 xlen_t'(first_debug_ins_o));
      wait_edge();
      check_registered(row_names[i], rows[i]);
    end

    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
design/riscv_isa_pkg.sv
design/debug_pkg.sv
design/retire_event_if.sv
design/wb_retire_classifier.sv
design/debug_cause_tracker.sv
design/dpc_predictor.sv
design/debug_entry_capture.sv
design/debug_monitor.sv
verif/debug_monitor_sva.sv
verif/debug_monitor_tb.sv

// ==== Bender.yml ====
package:
  name: debug_monitor

sources:
  - files:
      - design/riscv_isa_pkg.sv
      - design/debug_pkg.sv
      - design/retire_event_if.sv
      - design/wb_retire_classifier.sv
      - design/debug_cause_tracker.sv
      - design/dpc_predictor.sv
      - design/debug_entry_capture.sv
      - design/debug_monitor.sv
  - target: test
    files:
      - verif/debug_monitor_sva.sv
      - verif/debug_monitor_tb.sv
